// File: bench/wtc_dcache_tb.sv
//////////////////////////////
// dcache testbench
// directed and random loads/stores
// against a shadow memory
//////////////////////////////
module wtc_dcache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import wtc_pkg::*;

  localparam logic [31:0] SEED       = 32'h69c2_0795;
  localparam int unsigned RAND_OPS   = 300;
  localparam int unsigned GNT_LIMIT  = 100;
  localparam int unsigned RSP_LIMIT  = 100;
  localparam int unsigned IDLE_LIMIT = 200;
  // budget of 40 cycles per op over the directed and random tests
  localparam int unsigned TEST_OPS   = 60 + RAND_OPS;
  localparam int unsigned TIMEOUT_NS = (TEST_OPS * 40 + 400) * 40;

  logic      clk_i = 1'b0;
  logic      rst_i;
  logic      enable, flush, flush_ack, miss, busy;
  logic      hold;
  logic [1:0] delay;
  ld_req_t   ld_req;
  ld_rsp_t   ld_rsp;
  logic      ld_gnt;
  st_req_t   st_req;
  logic      st_gnt;
  mem_req_t  mem_req;
  logic      mem_credit;
  mem_rtrn_t mem_rtrn;

  logic [31:0] shadow [int unsigned];
  logic [31:0] exp_q [$];
  logic [31:0] lat_state = ~SEED;

  int unsigned cyc = 0;
  int unsigned miss_cnt = 0;
  int unsigned ack_cnt = 0;
  int unsigned stall_cnt = 0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned tests = 0;

  always #20 clk_i = ~clk_i;

  wtc_dcache u_wtc_dcache (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .enable_i     (enable),
    .flush_i      (flush),
    .flush_ack_o  (flush_ack),
    .miss_o       (miss),
    .busy_o       (busy),
    .ld_req_i     (ld_req),
    .ld_gnt_o     (ld_gnt),
    .ld_rsp_o     (ld_rsp),
    .st_req_i     (st_req),
    .st_gnt_o     (st_gnt),
    .mem_req_o    (mem_req),
    .mem_credit_i (mem_credit),
    .mem_rtrn_i   (mem_rtrn)
  );

  wtc_mem_model u_mem_model (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .hold_i       (hold),
    .delay_i      (delay),
    .mem_req_i    (mem_req),
    .mem_credit_o (mem_credit),
    .mem_rtrn_o   (mem_rtrn)
  );

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(logic [13:0] w);
    return {w, 2'b10, w ^ 14'h1d3b, 2'b01};
  endfunction

  function automatic int unsigned word_index(addr_t addr);
    return 32'(addr[ADDR_W-1:2]);
  endfunction

  // expected load data from the last store or the start-up content
  function automatic logic [31:0] ref_load(addr_t addr);
    int unsigned w;
    w = word_index(addr);
    if (shadow.exists(w)) begin
      return shadow[w];
    end
    return fill_word(14'(w));
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t line_base(logic [1:0] sel);
    case (sel)
      2'd0:    return 16'h0400;
      2'd1:    return 16'h0410;
      2'd2:    return 16'h1400;
      default: return 16'h0420;
    endcase
  endfunction

  ////////////////////////////////
  // checks and bus tasks
  ////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic store_word(input addr_t addr, input logic [31:0] data, input logic [3:0] be);
    int unsigned n;
    @(negedge clk_i);
    st_req.valid = 1'b1;
    st_req.addr  = addr;
    st_req.data  = data;
    st_req.be    = be;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!st_gnt && n < GNT_LIMIT);
    if (st_gnt) begin
      shadow[word_index(addr)] = merge_bytes(ref_load(addr), data, be);
    end else begin
      errors++;
      $display("store to 0x%h was never granted", addr);
    end
    @(negedge clk_i);
    st_req.valid = 1'b0;
  endtask

  // latency and miss pulses counted from acceptance to response
  task automatic load_word(input addr_t addr, output int unsigned lat,
                           output int unsigned misses);
    int unsigned n, t0, m0;
    lat    = 0;
    misses = 0;
    @(negedge clk_i);
    ld_req.valid = 1'b1;
    ld_req.addr  = addr;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!ld_gnt && n < GNT_LIMIT);
    if (!ld_gnt) begin
      errors++;
      $display("load from 0x%h was never granted", addr);
      @(negedge clk_i);
      ld_req.valid = 1'b0;
    end else begin
      exp_q.push_back(ref_load(addr));
      t0 = cyc;
      m0 = miss_cnt;
      @(negedge clk_i);
      ld_req.valid = 1'b0;
      n = 0;
      do begin
        @(posedge clk_i);
        n++;
      end while (!ld_rsp.valid && n < RSP_LIMIT);
      if (ld_rsp.valid) begin
        lat    = cyc - t0;
        misses = miss_cnt - m0;
      end else begin
        errors++;
        $display("load from 0x%h got no response", addr);
      end
    end
  endtask

  task automatic flush_cache(output int unsigned acks);
    int unsigned n, a0;
    @(negedge clk_i);
    a0    = ack_cnt;
    flush = 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!flush_ack && n < IDLE_LIMIT);
    if (!flush_ack) begin
      errors++;
      $display("flush was never acknowledged");
    end
    @(negedge clk_i);
    flush = 1'b0;
    repeat (4) @(posedge clk_i);
    acks = ack_cnt - a0;
  endtask

  task automatic wait_idle();
    int unsigned n;
    repeat (2) @(posedge clk_i);
    n = 0;
    while (busy && n < IDLE_LIMIT) begin
      @(posedge clk_i);
      n++;
    end
    if (busy) begin
      errors++;
      $display("cache stayed busy after the last request");
    end
  endtask

  task automatic compare_memory();
    foreach (shadow[k]) begin
      check_value($sformatf("mem_model word 0x%h", k << 2), u_mem_model.mem_q[k], shadow[k]);
    end
  endtask

  task automatic report_test(input string name, input int unsigned err0);
    tests++;
    $display("test %0d %s: %s, %0d errors", tests, name,
             (errors == err0) ? "ok" : "FAILED", errors - err0);
  endtask

  ////////////////////////////////
  // monitors
  ////////////////////////////////

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (miss) begin
      miss_cnt <= miss_cnt + 1;
    end
    if (flush_ack) begin
      ack_cnt <= ack_cnt + 1;
    end
    if (st_req.valid && !st_gnt) begin
      stall_cnt <= stall_cnt + 1;
    end
  end

  // memory latency stream
  always @(negedge clk_i) begin
    lat_state = lcg_next(lat_state);
    delay     = lat_state[31:30];
  end

  // every response against the oldest expected value
  always @(posedge clk_i) begin
    logic [31:0] exp;
    if (!rst_i && ld_rsp.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("load response at %0d ns without a pending load", $time);
      end else begin
        exp = exp_q.pop_front();
        check_value("ld_rsp_o.data", ld_rsp.data, exp);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////
  // test sequence
  ////////////////////////////////

  initial begin
    int unsigned lat, misses, acks, err0, s0;
    logic [31:0] rnd;
    logic [3:0]  be;
    addr_t       a;
    rst_i  = 1'b1;
    enable = 1'b1;
    flush  = 1'b0;
    hold   = 1'b0;
    delay  = 2'd0;
    ld_req = '0;
    st_req = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    repeat (3) @(negedge clk_i);

    err0 = errors;
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses on first load", misses, 1);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses on second load", misses, 0);
    check_value("ld_rsp_o hit latency", lat, 2);
    report_test("miss then hit", err0);

    err0 = errors;
    store_word(16'h0104, 32'hdead_beef, 4'b1111);
    store_word(16'h0108, 32'h1234_5678, 4'b0101);
    store_word(16'h0230, 32'hcafe_f00d, 4'b1000);
    store_word(16'h0234, 32'h0bad_c0de, 4'b0110);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses on stored hit", misses, 0);
    load_word(16'h0108, lat, misses);
    load_word(16'h010c, lat, misses);
    load_word(16'h0230, lat, misses);
    check_value("miss_o pulses on uncached store line", misses, 1);
    load_word(16'h0234, lat, misses);
    load_word(16'h0380, lat, misses);
    wait_idle();
    compare_memory();
    report_test("write-through", err0);

    err0 = errors;
    @(negedge clk_i);
    hold = 1'b1;
    s0   = stall_cnt;
    fork
      begin
        for (int i = 0; i < 7; i++) begin
          store_word(16'h0350 + 16'(4 * i), 32'hb0b0_0000 + 32'(i),
                     (i % 3 == 0) ? 4'b1111 : ((i % 3 == 1) ? 4'b0011 : 4'b1100));
        end
      end
      begin
        repeat (40) @(posedge clk_i);
        check_value("st_gnt_o dropped while credits held", {31'd0, stall_cnt != s0}, 1);
        check_value("busy_o while credits held", {31'd0, busy}, 1);
        @(negedge clk_i);
        hold = 1'b0;
      end
    join
    for (int i = 0; i < 7; i++) begin
      load_word(16'h0350 + 16'(4 * i), lat, misses);
    end
    wait_idle();
    compare_memory();
    report_test("back-pressure", err0);

    err0 = errors;
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses before flush", misses, 0);
    flush_cache(acks);
    check_value("flush_ack_o pulses", acks, 1);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses after flush", misses, 1);
    report_test("flush", err0);

    err0 = errors;
    @(negedge clk_i);
    enable = 1'b0;
    repeat (3) @(negedge clk_i);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses while disabled", misses, 1);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses while disabled", misses, 1);
    store_word(16'h0108, 32'h5555_aaaa, 4'b1001);
    load_word(16'h0108, lat, misses);
    check_value("miss_o pulses while disabled", misses, 1);
    @(negedge clk_i);
    enable = 1'b1;
    repeat (3) @(negedge clk_i);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses after enable", misses, 1);
    load_word(16'h0104, lat, misses);
    check_value("miss_o pulses on refilled line", misses, 0);
    report_test("disabled cache", err0);

    err0 = errors;
    rnd  = SEED;
    for (int i = 0; i < RAND_OPS; i++) begin
      rnd = lcg_next(rnd);
      a   = line_base(rnd[21:20]) | {12'h000, rnd[19:18], 2'b00};
      if (rnd[31:29] < 3'd3) begin
        be  = rnd[27:24];
        rnd = lcg_next(rnd);
        store_word(a, rnd, be);
      end else begin
        load_word(a, lat, misses);
      end
    end
    wait_idle();
    compare_memory();
    report_test("random mix", err0);

    wait_idle();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d load responses never arrived", exp_q.size());
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: bench/wtc_mem_model.sv
//////////////////////////////
// main memory model
// in-order service, random latency,
// one credit back per request
//////////////////////////////
module wtc_mem_model (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               hold_i,
  input  logic [1:0]         delay_i,
  input  wtc_pkg::mem_req_t  mem_req_i,
  output logic               mem_credit_o,
  output wtc_pkg::mem_rtrn_t mem_rtrn_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import wtc_pkg::*;

  localparam int WORDS = 2 ** (ADDR_W - 2);

  logic [WORD_W-1:0] mem_q [WORDS];
  mem_req_t          pend_q [$];
  mem_req_t          head;
  int unsigned       wait_cnt;
  logic              active;

  // start-up content, a function of the word address
  function automatic logic [WORD_W-1:0] fill_word(logic [ADDR_W-3:0] w);
    return {w, 2'b10, w ^ 14'h1d3b, 2'b01};
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem_q[i] = fill_word(14'(i));
    end
    mem_credit_o = 1'b0;
    mem_rtrn_o   = '0;
    active       = 1'b0;
    wait_cnt     = 0;
  end

  always @(posedge clk_i) begin
    line_t line;
    line = '0;
    mem_credit_o     <= 1'b0;
    mem_rtrn_o.valid <= 1'b0;
    if (rst_i) begin
      pend_q.delete();
      active = 1'b0;
    end else begin
      if (mem_req_i.valid) begin
        pend_q.push_back(mem_req_i);
      end
      if (!active && pend_q.size() != 0) begin
        head     = pend_q.pop_front();
        wait_cnt = delay_i;
        active   = 1'b1;
      end else if (active) begin
        if (wait_cnt != 0) begin
          wait_cnt--;
        end else if (!hold_i) begin
          // finished: apply the store or return the line, then the credit
          if (head.we) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
              if (head.be[b]) begin
                mem_q[head.addr[ADDR_W-1:2]][b*8 +: 8] = head.data[b*8 +: 8];
              end
            end
          end else begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
              line[k*WORD_W +: WORD_W] = mem_q[{head.addr[ADDR_W-1:OFF_W], 2'(k)}];
            end
            mem_rtrn_o.valid <= 1'b1;
            mem_rtrn_o.line  <= line;
          end
          mem_credit_o <= 1'b1;
          active = 1'b0;
        end
      end
    end
  end

endmodule

// File: rtl/wtc_dcache.sv
//////////////////////////////
// write-through L1 dcache top
// direct-mapped, one load port
// and one store port
//////////////////////////////
module wtc_dcache #(
  parameter int unsigned MemCredits = 2,
  parameter int unsigned WbufDepth  = 4
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               enable_i,
  input  logic               flush_i,
  output logic               flush_ack_o,
  output logic               miss_o,
  output logic               busy_o,
  input  wtc_pkg::ld_req_t   ld_req_i,
  output logic               ld_gnt_o,
  output wtc_pkg::ld_rsp_t   ld_rsp_o,
  input  wtc_pkg::st_req_t   st_req_i,
  output logic               st_gnt_o,
  output wtc_pkg::mem_req_t  mem_req_o,
  input  logic               mem_credit_i,
  input  wtc_pkg::mem_rtrn_t mem_rtrn_i
);
  import wtc_pkg::*;

  // ld_ctrl <-> mem
  logic             rd_req, rd_ack, rd_valid;
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  line_t            rd_line;

  // ld_ctrl <-> missunit
  logic  miss_req, miss_done, cache_en;
  addr_t miss_addr;
  line_t miss_line;

  // wbuffer <-> mem
  logic                wr_req, wr_ack, wr_pending;
  addr_t               wr_addr;
  logic [WORD_W-1:0]   wr_data;
  logic [WORD_W/8-1:0] wr_be;

  // wbuffer <-> missunit
  logic      wb_valid, wb_pop, wb_empty;
  wb_entry_t wb_head;

  // missunit -> mem
  logic             cl_we, inv_all;
  logic [IDX_W-1:0] cl_idx;
  logic [TAG_W-1:0] cl_tag;
  line_t            cl_line;

  logic ld_busy, mu_busy;

  assign busy_o = ld_busy || mu_busy || !wb_empty;

  wtc_ld_ctrl u_ld_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cache_en_i   (cache_en),
    .ld_req_i     (ld_req_i),
    .ld_gnt_o     (ld_gnt_o),
    .ld_rsp_o     (ld_rsp_o),
    .wr_pending_i (wr_pending),
    .rd_req_o     (rd_req),
    .rd_idx_o     (rd_idx),
    .rd_ack_i     (rd_ack),
    .rd_tag_i     (rd_tag),
    .rd_valid_i   (rd_valid),
    .rd_line_i    (rd_line),
    .miss_req_o   (miss_req),
    .miss_addr_o  (miss_addr),
    .miss_done_i  (miss_done),
    .miss_line_i  (miss_line),
    .busy_o       (ld_busy)
  );

  wtc_wbuffer #(
    .WbufDepth (WbufDepth)
  ) u_wbuffer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .st_req_i     (st_req_i),
    .st_gnt_o     (st_gnt_o),
    .wr_req_o     (wr_req),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .wr_be_o      (wr_be),
    .wr_ack_i     (wr_ack),
    .wr_pending_o (wr_pending),
    .wb_valid_o   (wb_valid),
    .wb_head_o    (wb_head),
    .wb_pop_i     (wb_pop),
    .wb_empty_o   (wb_empty)
  );

  wtc_missunit #(
    .MemCredits (MemCredits)
  ) u_missunit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .enable_i     (enable_i),
    .flush_i      (flush_i),
    .flush_ack_o  (flush_ack_o),
    .miss_o       (miss_o),
    .busy_o       (mu_busy),
    .cache_en_o   (cache_en),
    .miss_req_i   (miss_req),
    .miss_addr_i  (miss_addr),
    .miss_done_o  (miss_done),
    .miss_line_o  (miss_line),
    .wb_valid_i   (wb_valid),
    .wb_head_i    (wb_head),
    .wb_pop_o     (wb_pop),
    .wb_empty_i   (wb_empty),
    .cl_we_o      (cl_we),
    .cl_idx_o     (cl_idx),
    .cl_tag_o     (cl_tag),
    .cl_line_o    (cl_line),
    .inv_all_o    (inv_all),
    .mem_req_o    (mem_req_o),
    .mem_credit_i (mem_credit_i),
    .mem_rtrn_i   (mem_rtrn_i)
  );

  wtc_mem u_mem (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_req_i   (rd_req),
    .rd_idx_i   (rd_idx),
    .rd_ack_o   (rd_ack),
    .rd_tag_o   (rd_tag),
    .rd_valid_o (rd_valid),
    .rd_line_o  (rd_line),
    .wr_req_i   (wr_req),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .wr_be_i    (wr_be),
    .wr_ack_o   (wr_ack),
    .cl_we_i    (cl_we),
    .cl_idx_i   (cl_idx),
    .cl_tag_i   (cl_tag),
    .cl_line_i  (cl_line),
    .inv_all_i  (inv_all)
  );

endmodule

// File: rtl/wtc_ld_ctrl.sv
//////////////////////////////
// load controller
// lookup, hit/miss decision and
// miss path through the miss unit
//////////////////////////////
module wtc_ld_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      cache_en_i,
  // load port
  input  wtc_pkg::ld_req_t          ld_req_i,
  output logic                      ld_gnt_o,
  output wtc_pkg::ld_rsp_t          ld_rsp_o,
  input  logic                      wr_pending_i,
  // array read port
  output logic                      rd_req_o,
  output logic [wtc_pkg::IDX_W-1:0] rd_idx_o,
  input  logic                      rd_ack_i,
  input  logic [wtc_pkg::TAG_W-1:0] rd_tag_i,
  input  logic                      rd_valid_i,
  input  wtc_pkg::line_t            rd_line_i,
  // miss unit
  output logic                      miss_req_o,
  output wtc_pkg::addr_t            miss_addr_o,
  input  logic                      miss_done_i,
  input  wtc_pkg::line_t            miss_line_i,
  output logic                      busy_o
);
  import wtc_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_MISS} state_e;

  state_e  state_q, state_d;
  addr_t   addr_q;
  ld_rsp_t rsp_q, rsp_d;
  logic    accept, hit, open_q;

  // no grant while a store word write is still on its way to the array
  assign rd_req_o = (state_q == ST_IDLE) && ld_req_i.valid && cache_en_i && !wr_pending_i;
  assign rd_idx_o = addr_idx(ld_req_i.addr);
  assign ld_gnt_o = (state_q == ST_IDLE) && !wr_pending_i && (cache_en_i ? rd_ack_i : 1'b1);
  assign accept   = ld_req_i.valid && ld_gnt_o;

  assign hit         = rd_valid_i && (rd_tag_i == addr_tag(addr_q));
  assign miss_req_o  = (state_q == ST_MISS);
  assign miss_addr_o = addr_q;
  assign ld_rsp_o    = rsp_q;
  assign busy_o      = (state_q != ST_IDLE);

  always_comb begin
    state_d     = state_q;
    rsp_d.valid = 1'b0;
    rsp_d.data  = rsp_q.data;
    unique case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = cache_en_i ? ST_LOOKUP : ST_MISS;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          state_d     = ST_IDLE;
          rsp_d.valid = 1'b1;
          rsp_d.data  = line_word(rd_line_i, addr_q);
        end else begin
          state_d = ST_MISS;
        end
      end
      ST_MISS: begin
        if (miss_done_i) begin
          state_d     = ST_IDLE;
          rsp_d.valid = 1'b1;
          rsp_d.data  = line_word(miss_line_i, addr_q);
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      rsp_q.valid <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_q.valid <= rsp_d.valid;
    end
    rsp_q.data <= rsp_d.data;
    if (accept) begin
      addr_q <= ld_req_i.addr;
    end
  end

  // open from acceptance up to its response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      open_q <= 1'b0;
    end else if (accept) begin
      open_q <= 1'b1;
    end else if (ld_rsp_o.valid) begin
      open_q <= 1'b0;
    end
  end

  a_single_load: assert property (@(posedge clk_i) disable iff (rst_i)
    accept |-> (!open_q || ld_rsp_o.valid));

endmodule

// File: rtl/wtc_mem.sv
//////////////////////////////
// dcache arrays
// tag, valid and data storage with
// refill, word-write and read ports
//////////////////////////////
module wtc_mem (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // load read port
  input  logic                        rd_req_i,
  input  logic [wtc_pkg::IDX_W-1:0]   rd_idx_i,
  output logic                        rd_ack_o,
  output logic [wtc_pkg::TAG_W-1:0]   rd_tag_o,
  output logic                        rd_valid_o,
  output wtc_pkg::line_t              rd_line_o,
  // store word-write port
  input  logic                        wr_req_i,
  input  wtc_pkg::addr_t              wr_addr_i,
  input  logic [wtc_pkg::WORD_W-1:0]  wr_data_i,
  input  logic [wtc_pkg::WORD_W/8-1:0] wr_be_i,
  output logic                        wr_ack_o,
  // refill and invalidate
  input  logic                        cl_we_i,
  input  logic [wtc_pkg::IDX_W-1:0]   cl_idx_i,
  input  logic [wtc_pkg::TAG_W-1:0]   cl_tag_i,
  input  wtc_pkg::line_t              cl_line_i,
  input  logic                        inv_all_i
);
  import wtc_pkg::*;

  localparam int SETS = 2 ** IDX_W;

  logic [TAG_W-1:0] tag_q  [SETS];
  line_t            data_q [SETS];
  logic [SETS-1:0]  valid_q;

  logic [IDX_W-1:0]   wr_idx;
  logic [OFF_W-3:0]   wr_sel;
  logic               wr_hit;

  // fixed priority of refill/invalidate over word write over load read
  assign wr_ack_o = wr_req_i && !cl_we_i && !inv_all_i;
  assign rd_ack_o = rd_req_i && !cl_we_i && !inv_all_i && !wr_req_i;

  assign wr_idx = addr_idx(wr_addr_i);
  assign wr_sel = wr_addr_i[OFF_W-1:2];
  assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == addr_tag(wr_addr_i));

  always_ff @(posedge clk_i) begin
    if (rst_i || inv_all_i) begin
      valid_q <= '0;
    end else if (cl_we_i) begin
      valid_q[cl_idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cl_we_i) begin
      tag_q[cl_idx_i]  <= cl_tag_i;
      data_q[cl_idx_i] <= cl_line_i;
    end else if (wr_ack_o && wr_hit) begin
      // stores never allocate and only patch hitting lines
      for (int b = 0; b < WORD_W/8; b++) begin
        if (wr_be_i[b]) begin
          data_q[wr_idx][wr_sel*WORD_W + b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  // read data lands one cycle after the ack
  always_ff @(posedge clk_i) begin
    if (rd_ack_o) begin
      rd_tag_o   <= tag_q[rd_idx_i];
      rd_valid_o <= valid_q[rd_idx_i];
      rd_line_o  <= data_q[rd_idx_i];
    end
  end

  // load side holds off while a word write waits, so both acks never meet
  a_one_port: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rd_req_i && wr_req_i));

endmodule

// File: rtl/wtc_missunit.sv
//////////////////////////////
// miss unit
// memory channel, credits, refill,
// flush and enable handling
//////////////////////////////
module wtc_missunit #(
  parameter int unsigned MemCredits = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      enable_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o,
  output logic                      miss_o,
  output logic                      busy_o,
  output logic                      cache_en_o,
  // load controller
  input  logic                      miss_req_i,
  input  wtc_pkg::addr_t            miss_addr_i,
  output logic                      miss_done_o,
  output wtc_pkg::line_t            miss_line_o,
  // write buffer
  input  logic                      wb_valid_i,
  input  wtc_pkg::wb_entry_t        wb_head_i,
  output logic                      wb_pop_o,
  input  logic                      wb_empty_i,
  // array refill and invalidate
  output logic                      cl_we_o,
  output logic [wtc_pkg::IDX_W-1:0] cl_idx_o,
  output logic [wtc_pkg::TAG_W-1:0] cl_tag_o,
  output wtc_pkg::line_t            cl_line_o,
  output logic                      inv_all_o,
  // memory channel
  output wtc_pkg::mem_req_t         mem_req_o,
  input  logic                      mem_credit_i,
  input  wtc_pkg::mem_rtrn_t        mem_rtrn_i
);
  import wtc_pkg::*;

  localparam int unsigned CntW = $clog2(MemCredits + 1);
  localparam logic [CntW-1:0] FULL_CREDITS = CntW'(MemCredits);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_INV, ST_ACK} state_e;

  state_e          state_q, state_d;
  logic [CntW-1:0] credits_q;
  logic            has_credit, send_st, send_rd, rtrn;
  logic            en_q, stale_q, head_same;

  assign has_credit = (credits_q != '0);

  // stores go first, a refill read waits for an empty buffer
  assign send_st = wb_valid_i && has_credit;
  assign send_rd = (state_q == ST_IDLE) && !flush_i && miss_req_i && wb_empty_i && has_credit;
  assign rtrn    = (state_q == ST_WAIT) && mem_rtrn_i.valid;

  assign wb_pop_o    = send_st;
  assign miss_o      = send_rd;
  assign miss_done_o = rtrn;
  assign miss_line_o = mem_rtrn_i.line;

  always_comb begin
    mem_req_o       = '0;
    mem_req_o.valid = send_st || send_rd;
    if (send_st) begin
      mem_req_o.we   = 1'b1;
      mem_req_o.addr = wb_head_i.addr;
      mem_req_o.data = wb_head_i.data;
      mem_req_o.be   = wb_head_i.be;
    end else begin
      mem_req_o.addr = {miss_addr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    end
  end

  // a store to the set queued after the read makes the line stale
  assign head_same = wb_valid_i && (addr_idx(wb_head_i.addr) == addr_idx(miss_addr_i));

  assign cl_we_o   = rtrn && enable_i && !stale_q && !head_same;
  assign cl_idx_o  = addr_idx(miss_addr_i);
  assign cl_tag_o  = addr_tag(miss_addr_i);
  assign cl_line_o = mem_rtrn_i.line;

  // drop all lines on flush or when the cache is switched off
  assign inv_all_o   = (state_q == ST_INV) || (en_q && !enable_i);
  assign cache_en_o  = en_q;
  assign flush_ack_o = (state_q == ST_ACK);
  assign busy_o      = (state_q != ST_IDLE) || (credits_q != FULL_CREDITS);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (flush_i && wb_empty_i) begin
          state_d = ST_INV;
        end else if (send_rd) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: if (mem_rtrn_i.valid) state_d = ST_IDLE;
      ST_INV:  state_d = ST_ACK;
      ST_ACK:  state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      credits_q <= FULL_CREDITS;
      en_q      <= 1'b0;
      stale_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      credits_q <= credits_q - CntW'(mem_req_o.valid) + CntW'(mem_credit_i);
      en_q      <= enable_i;
      if (send_rd) begin
        stale_q <= 1'b0;
      end else if (state_q == ST_WAIT && head_same) begin
        stale_q <= 1'b1;
      end
    end
  end

  a_credit_range: assert property (@(posedge clk_i) disable iff (rst_i)
    credits_q <= FULL_CREDITS);
  // memory never returns a credit that was not spent
  a_credit_return: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_credit_i |-> (credits_q != FULL_CREDITS) || mem_req_o.valid);

endmodule

// File: rtl/wtc_pkg.sv
//////////////////////////////
// write-through dcache package
// address split, port structs and
// line helper functions
//////////////////////////////
package wtc_pkg;

  // address split
  localparam int ADDR_W         = 16;
  localparam int WORD_W         = 32;
  localparam int OFF_W          = 4;
  localparam int IDX_W          = 4;
  localparam int TAG_W          = 8;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ld_req_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } ld_rsp_t;

  typedef struct packed {
    logic                valid;
    addr_t               addr;
    logic [WORD_W-1:0]   data;
    logic [WORD_W/8-1:0] be;
  } st_req_t;

  // we=1 store word, we=0 line read at line-aligned addr
  typedef struct packed {
    logic                valid;
    logic                we;
    addr_t               addr;
    logic [WORD_W-1:0]   data;
    logic [WORD_W/8-1:0] be;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    line_t line;
  } mem_rtrn_t;

  typedef struct packed {
    addr_t               addr;
    logic [WORD_W-1:0]   data;
    logic [WORD_W/8-1:0] be;
  } wb_entry_t;

  function automatic logic [IDX_W-1:0] addr_idx(addr_t addr);
    return addr[OFF_W +: IDX_W];
  endfunction

  function automatic logic [TAG_W-1:0] addr_tag(addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  // word of a line picked by addr[3:2]
  function automatic logic [WORD_W-1:0] line_word(line_t line, addr_t addr);
    return line[addr[OFF_W-1:2]*WORD_W +: WORD_W];
  endfunction

endpackage

// File: rtl/wtc_wbuffer.sv
//////////////////////////////
// write buffer
// store FIFO, patches hitting lines
// and feeds the miss unit
//////////////////////////////
module wtc_wbuffer #(
  parameter int unsigned WbufDepth = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // store port
  input  wtc_pkg::st_req_t             st_req_i,
  output logic                         st_gnt_o,
  // array word-write port
  output logic                         wr_req_o,
  output wtc_pkg::addr_t               wr_addr_o,
  output logic [wtc_pkg::WORD_W-1:0]   wr_data_o,
  output logic [wtc_pkg::WORD_W/8-1:0] wr_be_o,
  input  logic                         wr_ack_i,
  output logic                         wr_pending_o,
  // miss unit side
  output logic                         wb_valid_o,
  output wtc_pkg::wb_entry_t           wb_head_o,
  input  logic                         wb_pop_i,
  output logic                         wb_empty_o
);
  import wtc_pkg::*;

  localparam int unsigned PtrW = (WbufDepth > 1) ? $clog2(WbufDepth) : 1;
  localparam logic [PtrW-1:0] LAST  = PtrW'(WbufDepth - 1);
  localparam logic [PtrW:0]   DEPTH = (PtrW + 1)'(WbufDepth);

  wb_entry_t       fifo_q [WbufDepth];
  wb_entry_t       new_entry, pend_entry_q;
  logic [PtrW-1:0] head_q, tail_q;
  logic [PtrW:0]   count_q;
  logic            pend_q, full, push;

  assign new_entry = '{addr: st_req_i.addr, data: st_req_i.data, be: st_req_i.be};

  // one word write in flight and a new store may take the slot as it frees
  assign full     = (count_q == DEPTH);
  assign st_gnt_o = !full && (!pend_q || wr_ack_i);
  assign push     = st_req_i.valid && st_gnt_o;

  assign wr_req_o     = pend_q;
  assign wr_addr_o    = pend_entry_q.addr;
  assign wr_data_o    = pend_entry_q.data;
  assign wr_be_o      = pend_entry_q.be;
  assign wr_pending_o = pend_q || push;

  assign wb_valid_o = (count_q != '0);
  assign wb_empty_o = (count_q == '0);
  assign wb_head_o  = fifo_q[head_q];

  ////////////////////////////////
  // pointers and count
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      pend_q  <= 1'b0;
    end else begin
      if (push) begin
        tail_q <= (tail_q == LAST) ? '0 : tail_q + 1'b1;
      end
      if (wb_pop_i) begin
        head_q <= (head_q == LAST) ? '0 : head_q + 1'b1;
      end
      count_q <= count_q + (PtrW + 1)'(push) - (PtrW + 1)'(wb_pop_i);
      if (push) begin
        pend_q <= 1'b1;
      end else if (wr_ack_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[tail_q] <= new_entry;
      pend_entry_q   <= new_entry;
    end
  end

  // a push never lands on the slot of a queued entry
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push |-> !(count_q != '0 && tail_q == head_q));
  // miss unit only pops what is queued
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_pop_i |-> wb_valid_o);

endmodule

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f wtc_dcache.f --top-module wtc_dcache_tb -o wtc_dcache_sim

out=$(./obj_dir/wtc_dcache_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// File: wtc_dcache.f
rtl/wtc_pkg.sv
rtl/wtc_mem.sv
rtl/wtc_ld_ctrl.sv
rtl/wtc_wbuffer.sv
rtl/wtc_missunit.sv
rtl/wtc_dcache.sv
bench/wtc_mem_model.sv
bench/wtc_dcache_tb.sv
